// ==== source/backup_sync.sv ====
// Backup RAM sync
// Tracks whether the battery RAM holds unsaved writes and moves it to
// and from the mounted save image one sector at a time over the SD
// request interface
`timescale 1ns/1ps
`default_nettype none

module backup_sync (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  load_pkg::dl_kind_t   kind,
	input  cart_pkg::mem_mask_t  ram_mask,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	input  logic [63:0]          img_size,
	input  cart_pkg::cart_cfg_t  cfg,
	input  logic                 bsram_write,
	input  logic                 osd_open,
	input  logic                 sd_ack,
	output cart_pkg::lba_t       sd_lba,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output logic                 bk_loading,
	output logic                 bk_busy,
	output logic                 bk_pending
);
	import cart_pkg::*;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_t;

	bk_state_t state;
	logic      bk_ena;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      load_go;
	logic      save_go;
	logic      load_trig;
	logic      save_trig;
	logic      boot_trig;
	logic      xfer_begin;
	logic      xfer_load;
	logic      sector_done;
	logic      last_sector;
	lba_t      last_lba;

	assign last_lba = lba_t'(ram_mask >> SECTOR_SHIFT);

	// ====================
	// Triggers
	// ====================
	assign load_go   = cfg.load_req & bk_ena;
	assign save_go   = (cfg.save_req | (bk_pending & osd_open & cfg.autosave)) & bk_ena;
	assign load_trig = load_go & ~old_load;
	assign save_trig = save_go & ~old_save;
	// Save file gets restored right after the image has loaded
	assign boot_trig = kind.finish & (img_size != 64'd0) & bk_ena;

	assign xfer_begin  = (state == BK_IDLE) & (boot_trig | load_trig | save_trig);
	assign xfer_load   = boot_trig | load_trig;
	assign sector_done = (state == BK_XFER) & old_ack & ~sd_ack;
	assign last_sector = (sd_lba >= last_lba);

	assign bk_busy = (state == BK_XFER);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			old_load <= load_go;
			old_save <= save_go;
			old_ack  <= sd_ack;

			if (kind.start)
				bk_ena <= 1'b0;
			else if (kind.cart_active & img_mounted & ~img_readonly)
				bk_ena <= |ram_mask;

			// Writes while the menu is up do not count
			if (bk_ena & ~osd_open & bsram_write)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ====================
	// Sector sequencing
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			// Request level drops once the SD side has taken it
			if (~old_ack & sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (xfer_begin) begin
						state      <= BK_XFER;
						bk_loading <= xfer_load;
						sd_rd      <= xfer_load;
						sd_wr      <= ~xfer_load;
					end
				end
				BK_XFER: begin
					if (sector_done) begin
						if (last_sector) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (xfer_begin)
			sd_lba <= '0;
		else if (sector_done & ~last_sector)
			sd_lba <= sd_lba + 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/cart_header_detect.sv ====
// Cartridge header detect
// Watches the image as it streams in and picks out the map type, the
// ROM and RAM size codes and the video region, either from the leading
// info word or from the internal header at the offset of the chosen mode
`timescale 1ns/1ps
`default_nettype none

module cart_header_detect (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  load_pkg::dl_bus_t      dl,
	input  load_pkg::dl_kind_t     kind,
	input  cart_pkg::header_mode_t mode,
	input  cart_pkg::region_sel_t  region_sel,
	output cart_pkg::cart_info_t   info
);
	import load_pkg::*;
	import cart_pkg::*;

	size_code_t rom_size;
	size_code_t rom_size_nx;
	size_code_t ram_size;
	size_code_t ram_size_nx;
	map_type_t  rom_type_nx;
	logic       rom_region;
	logic       rom_region_nx;
	dl_addr_t   size_addr;
	dl_addr_t   ram_addr;
	logic       hdr_wr;
	logic       hdr_scan;

	function automatic mem_mask_t size_mask(size_code_t size);
		return (mem_mask_t'(1024) << size) - mem_mask_t'(1);
	endfunction

	assign hdr_wr   = kind.cart_active & dl.wr;
	assign hdr_scan = (mode == 3'd2) || (mode == 3'd3) || (mode == 3'd4);

	// Internal header location for the selected mapping
	always_comb begin
		case (mode)
			3'd3: begin
				size_addr = dl_addr_t'(HDR_LO_SIZE + HDR_HI_OFS);
				ram_addr  = dl_addr_t'(HDR_LO_RAM + HDR_HI_OFS);
			end
			3'd4: begin
				size_addr = dl_addr_t'(HDR_LO_SIZE + HDR_EXHI_OFS);
				ram_addr  = dl_addr_t'(HDR_LO_RAM + HDR_EXHI_OFS);
			end
			default: begin
				size_addr = dl_addr_t'(HDR_LO_SIZE);
				ram_addr  = dl_addr_t'(HDR_LO_RAM);
			end
		endcase
	end

	// ====================
	// Field decode
	// ====================
	always_comb begin
		rom_size_nx   = rom_size;
		ram_size_nx   = ram_size;
		rom_type_nx   = info.rom_type;
		rom_region_nx = rom_region;

		if (hdr_wr) begin
			if (dl.addr == '0) begin
				rom_size_nx = DEFAULT_ROM_SIZE;
				ram_size_nx = '0;
				case (mode)
					3'd1, 3'd2: rom_type_nx = 8'd0;
					3'd3:       rom_type_nx = 8'd1;
					3'd4:       rom_type_nx = 8'd2;
					default:    rom_type_nx = dl.dout[15:8];
				endcase
				// Auto mode trusts the info byte when it is present
				if (mode == 3'd0 && dl.dout[7:0] != 8'd0)
					{ram_size_nx, rom_size_nx} = dl.dout[7:0];
			end

			if (dl.addr == dl_addr_t'(2))
				rom_region_nx = dl.dout[8];

			if (hdr_scan) begin
				if (dl.addr == size_addr)
					rom_size_nx = dl.dout[11:8];
				if (dl.addr == ram_addr)
					ram_size_nx = dl.dout[3:0];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= '0;
			rom_region <= 1'b0;
			info       <= '0;
		end else begin
			rom_size      <= rom_size_nx;
			ram_size      <= ram_size_nx;
			rom_region    <= rom_region_nx;
			info.rom_type <= rom_type_nx;
			info.rom_mask <= size_mask(rom_size_nx);
			info.ram_mask <= (ram_size_nx != '0) ? size_mask(ram_size_nx) : '0;

			// Region only switches outside a cartridge load
			if (!kind.cart_active)
				info.pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

endmodule

`default_nettype wire

// ==== source/cart_loader_top.sv ====
// Cartridge loader top level
// Connects the load sequencer, header detect, cheat loader and backup
// RAM sync around the host download stream and the SD sector interface
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top (
	input  logic                                 clk_sys,
	input  logic                                 RESET,
	input  load_pkg::dl_bus_t                    dl,
	input  cart_pkg::cart_cfg_t                  cfg,
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic [63:0]                          img_size,
	input  logic                                 sd_ack,
	input  logic                                 bsram_write,
	input  logic                                 osd_open,
	output cart_pkg::cart_info_t                 info,
	output load_pkg::cheat_code_t                code,
	output logic                                 cheat_valid,
	output logic                                 cheat_reset,
	output logic [cart_pkg::CLEAR_ADDR_BITS-1:0] fill_addr,
	output logic                                 fill_wr,
	output logic                                 system_reset,
	output cart_pkg::lba_t                       sd_lba,
	output logic                                 sd_rd,
	output logic                                 sd_wr,
	output logic                                 bk_loading,
	output logic                                 bk_busy,
	output logic                                 bk_pending
);
	import load_pkg::*;

	dl_kind_t kind;

	// Menu reset joins the hard reset on the way into the core reset
	load_sequencer u_load_sequencer (
		.clk_sys      (clk_sys),
		.RESET        (RESET | cfg.user_reset),
		.dl           (dl),
		.bk_loading   (bk_loading),
		.kind         (kind),
		.fill_addr    (fill_addr),
		.fill_wr      (fill_wr),
		.system_reset (system_reset)
	);

	cart_header_detect u_cart_header_detect (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl),
		.kind       (kind),
		.mode       (cfg.header_mode),
		.region_sel (cfg.region_sel),
		.info       (info)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl          (dl),
		.kind        (kind),
		.code        (code),
		.cheat_valid (cheat_valid),
		.cheat_reset (cheat_reset)
	);

	backup_sync u_backup_sync (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.kind         (kind),
		.ram_mask     (info.ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.cfg          (cfg),
		.bsram_write  (bsram_write),
		.osd_open     (osd_open),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_loading   (bk_loading),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending)
	);

endmodule

`default_nettype wire

// ==== source/cart_pkg.sv ====
// Cartridge package
// Cartridge properties decoded from the image, menu settings, memory
// size encodings, the clear sweep length and backup RAM sector numbering
`default_nettype none

package cart_pkg;

	// ====================
	// Sizes and masks
	// ====================
	typedef logic [23:0] mem_mask_t;
	// Exponent over 1 KiB
	typedef logic [3:0]  size_code_t;
	typedef logic [7:0]  map_type_t;

	// 0 auto, 1 and 2 LoROM, 3 HiROM, 4 ExHiROM
	typedef logic [2:0]  header_mode_t;
	// 0 auto, 1 NTSC, 2 PAL
	typedef logic [1:0]  region_sel_t;

	typedef struct packed {
		map_type_t rom_type;
		mem_mask_t rom_mask;
		mem_mask_t ram_mask;
		logic      pal;
	} cart_info_t;

	// Settings coming from the menu
	typedef struct packed {
		header_mode_t header_mode;
		region_sel_t  region_sel;
		logic         user_reset;
		logic         autosave;
		logic         load_req;
		logic         save_req;
	} cart_cfg_t;

	typedef logic [31:0] lba_t;

	// ====================
	// Constants
	// ====================
	localparam int CLEAR_ADDR_BITS = 17;

	// Images may carry a copier header ahead of the ROM
	localparam int unsigned COPIER_HDR   = 512;
	localparam int unsigned HDR_LO_SIZE  = 'h7FD6 + COPIER_HDR;
	localparam int unsigned HDR_LO_RAM   = 'h7FD8 + COPIER_HDR;
	localparam int unsigned HDR_HI_OFS   = 'h8000;
	localparam int unsigned HDR_EXHI_OFS = 'h408000;

	localparam size_code_t DEFAULT_ROM_SIZE = 4'hC;

	// 512-byte sectors
	localparam int SECTOR_SHIFT = 9;

endpackage

`default_nettype wire

// ==== source/cheat_code_loader.sv ====
// Cheat code loader
// Collects the 16-bit words of a cheat file into a 128-bit code and
// strobes it out once the last word of each code has arrived
`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  load_pkg::dl_bus_t     dl,
	input  load_pkg::dl_kind_t    kind,
	output load_pkg::cheat_code_t code,
	output logic                  cheat_valid,
	output logic                  cheat_reset
);
	import load_pkg::*;

	logic       code_wr;
	logic [2:0] word_idx;
	logic [2:0] slot;
	logic       first_wr;

	// Even byte offsets only, 16 bytes per code
	assign code_wr  = kind.code_active & dl.wr & ~dl.addr[0];
	assign word_idx = dl.addr[3:1];

	// Fields fill top down, low word of each field first
	assign slot = {~word_idx[2:1], word_idx[0]};

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			code[slot*16 +: 16] <= dl.dout;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			first_wr    <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (word_idx == 3'(CHEAT_WORDS - 1));
			first_wr    <= code_wr && (dl.addr == '0);
		end
	end

	// Old codes are dropped on a new image or a new cheat file
	assign cheat_reset = kind.cart_active | first_wr;

endmodule

`default_nettype wire

// ==== source/load_pkg.sv ====
// Download stream package
// Types for the host download stream, the decoded load state and the
// cheat code format assembled from a cheat file
`default_nettype none

package load_pkg;

	// ====================
	// Host stream
	// ====================
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_word_t;
	// All ones selects a cheat file, anything else is a cartridge image
	typedef logic [7:0]  dl_index_t;

	typedef struct packed {
		logic      download;
		logic      wr;
		dl_index_t index;
		dl_addr_t  addr;
		dl_word_t  dout;
	} dl_bus_t;

	// Decoded load state, start and finish are single-cycle pulses
	typedef struct packed {
		logic cart_active;
		logic code_active;
		logic start;
		logic finish;
	} dl_kind_t;

	// ====================
	// Cheat codes
	// ====================
	// Flags, address, compare, replace from top to bottom, 32 bits each
	typedef logic [127:0] cheat_code_t;

	localparam int CHEAT_WORDS = 8;

endpackage

`default_nettype wire

// ==== source/load_sequencer.sv ====
// Load sequencer
// Splits the host download into cartridge and cheat traffic, marks the
// start and end of a cartridge load, sweeps the work memories clear after
// a load starts, and holds the core in reset while loading
`timescale 1ns/1ps
`default_nettype none

module load_sequencer (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	input  load_pkg::dl_bus_t                      dl,
	input  logic                                   bk_loading,
	output load_pkg::dl_kind_t                     kind,
	output logic [cart_pkg::CLEAR_ADDR_BITS-1:0]   fill_addr,
	output logic                                   fill_wr,
	output logic                                   system_reset
);
	import cart_pkg::*;

	logic cart_active;
	logic code_active;
	logic cart_prev;
	logic start_q;
	logic finish_q;
	logic clearing;

	assign code_active = dl.download & (&dl.index);
	assign cart_active = dl.download & ~(&dl.index);

	always_comb begin
		kind.cart_active = cart_active;
		kind.code_active = code_active;
		kind.start       = start_q;
		kind.finish      = finish_q;
	end

	// ====================
	// Edges and sweep
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_prev <= 1'b0;
			start_q   <= 1'b0;
			finish_q  <= 1'b0;
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			cart_prev <= cart_active;
			start_q   <= cart_active & ~cart_prev;
			finish_q  <= ~cart_active & cart_prev;

			// One write per location, ends after the last address
			if (start_q)
				clearing <= 1'b1;
			else if (&fill_addr)
				clearing <= 1'b0;

			if (clearing)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	assign fill_wr = clearing;

	// Core stays in reset until the image, the sweep and the backup restore are done
	assign system_reset = RESET | cart_active | bk_loading | clearing;

endmodule

`default_nettype wire

// ==== verification/cart_loader_asserts.sv ====
// Loader protocol assertions
// Bound to the loader top level, checks SD request exclusivity, the
// fill write window and the cheat strobe width
`timescale 1ns/1ps
`default_nettype none

module cart_loader_asserts (
	input logic clk_sys,
	input logic RESET,
	input logic sd_rd,
	input logic sd_wr,
	input logic fill_wr,
	input logic system_reset,
	input logic cheat_valid
);

	// One sector direction at a time
	sd_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	// Memories are only swept while the core is held
	fill_in_reset: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_wr |-> system_reset)
		else $error("fill_wr high without system_reset");

	valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid held for more than one cycle");

endmodule

bind cart_loader_top cart_loader_asserts u_asserts (
	.clk_sys      (clk_sys),
	.RESET        (RESET),
	.sd_rd        (sd_rd),
	.sd_wr        (sd_wr),
	.fill_wr      (fill_wr),
	.system_reset (system_reset),
	.cheat_valid  (cheat_valid)
);

`default_nettype wire

// ==== verification/cart_loader_tb.sv ====
// Cartridge loader testbench
// Streams random cartridge images and cheat files into the loader,
// answers SD sector requests and checks the outputs against a model
`timescale 1ns/1ps
`default_nettype none

module cart_loader_tb;
	import load_pkg::*;
	import cart_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int SWEEP_CYCLES = 1 << 17;
	localparam int N_LOADS      = 8;
	localparam int N_CHEATS     = 3;
	localparam longint WATCHDOG_CYCLES =
		16 + N_LOADS * (SWEEP_CYCLES + 200) + N_CHEATS * 80 + 3 * 16 * 20 + 2000;

	logic                       clk_sys;
	logic                       RESET;
	dl_bus_t                    dl;
	cart_cfg_t                  cfg;
	logic                       img_mounted;
	logic                       img_readonly;
	logic [63:0]                img_size;
	logic                       sd_ack;
	logic                       bsram_write;
	logic                       osd_open;
	cart_info_t                 info;
	cheat_code_t                code;
	logic                       cheat_valid;
	logic                       cheat_reset;
	logic [CLEAR_ADDR_BITS-1:0] fill_addr;
	logic                       fill_wr;
	logic                       system_reset;
	lba_t                       sd_lba;
	logic                       sd_rd;
	logic                       sd_wr;
	logic                       bk_loading;
	logic                       bk_busy;
	logic                       bk_pending;

	logic [31:0] lfsr_main;
	logic [31:0] lfsr_sd;
	int          errors;
	logic        exp_valid;
	logic        exp_first;
	cheat_code_t code_exp;
	int          valid_seen;
	time         rise_time;
	int          fill_cnt;
	logic        fill_prev;
	logic        cheat_prev;
	int          sweeps_done;
	int          loads_done;
	lba_t        exp_lba;
	logic        exp_rd;

	cart_loader_top dut (.*);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ====================
	// Helpers
	// ====================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v  = {v[30:0], st[0]};
		end
	endtask

	task automatic check_eq(input logic [127:0] got, input logic [127:0] want,
		input string msg);
		if (got !== want) begin
			errors++;
			$display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, msg, got, want);
			$display("TEST FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// Internal header size byte for each mapping past the copier header
	function automatic dl_addr_t hdr_size_addr(input header_mode_t mode);
		case (mode)
			3'd3:    return 25'h00FFD6 + 25'd512;
			3'd4:    return 25'h40FFD6 + 25'd512;
			default: return 25'h007FD6 + 25'd512;
		endcase
	endfunction

	function automatic cart_info_t header_model(input header_mode_t mode,
		input region_sel_t rsel, input dl_word_t d0, input dl_word_t d2,
		input dl_word_t dsz, input dl_word_t dram);
		size_code_t rom;
		size_code_t ram;
		cart_info_t r;
		rom = 4'hC;
		ram = 4'h0;
		case (mode)
			3'd1, 3'd2: r.rom_type = 8'd0;
			3'd3:       r.rom_type = 8'd1;
			3'd4:       r.rom_type = 8'd2;
			default:    r.rom_type = d0[15:8];
		endcase
		if (mode == 3'd0 && d0[7:0] != 8'd0) begin
			rom = d0[3:0];
			ram = d0[7:4];
		end
		if (mode >= 3'd2) begin
			rom = dsz[11:8];
			ram = dram[3:0];
		end
		r.rom_mask = (24'd1024 << rom) - 24'd1;
		r.ram_mask = (ram == 4'd0) ? 24'd0 : (24'd1024 << ram) - 24'd1;
		r.pal      = (rsel == 2'd0) ? d2[8] : rsel[1];
		return r;
	endfunction

	// Cheat outputs as the previous cycle should have left them
	task automatic check_cheat_outs;
		check_eq(cheat_valid, exp_valid, "cheat_valid");
		if (exp_valid) begin
			check_eq(code, code_exp, "cheat code");
			valid_seen++;
		end
		check_eq(cheat_reset, (dl.download && dl.index != 8'hFF) || exp_first, "cheat_reset");
	endtask

	task automatic write_word(input dl_addr_t addr, input dl_word_t data);
		@(negedge clk_sys);
		check_cheat_outs();
		dl.download = 1'b1;
		dl.wr       = 1'b1;
		dl.addr     = addr;
		dl.dout     = data;
		exp_valid   = (dl.index == 8'hFF) && (addr[3:0] == 4'd14);
		exp_first   = (dl.index == 8'hFF) && (addr == '0);
	endtask

	task automatic hold_idle(input int n);
		repeat (n) begin
			@(negedge clk_sys);
			check_cheat_outs();
			dl.wr     = 1'b0;
			exp_valid = 1'b0;
			exp_first = 1'b0;
		end
	endtask

	// ====================
	// Test sequences
	// ====================
	task automatic load_cart(input header_mode_t mode, input region_sel_t rsel,
		input dl_word_t d0, input dl_word_t d2, input dl_word_t dsz, input dl_word_t dram);
		logic [31:0] v;
		take_bits(lfsr_main, 8, v);
		cfg.header_mode = mode;
		cfg.region_sel  = rsel;
		dl.index        = (v[7:0] == 8'hFF) ? 8'h00 : v[7:0];
		write_word('0, d0);
		rise_time = $time;
		write_word(25'd2, d2);
		write_word(hdr_size_addr(mode), dsz);
		write_word(hdr_size_addr(mode) + 25'd2, dram);
		hold_idle(4);
		dl.download = 1'b0;
	endtask

	task automatic finish_sweep;
		while (fill_wr)
			@(negedge clk_sys);
		hold_idle(1);
		check_eq(system_reset, 1'b0, "system_reset after sweep");
		loads_done++;
		check_eq(sweeps_done, loads_done, "clear sweeps completed");
	endtask

	task automatic header_case(input header_mode_t mode);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		take_bits(lfsr_main, 32, a);
		take_bits(lfsr_main, 32, b);
		take_bits(lfsr_main, 2, r);
		load_cart(mode, r[1:0], a[15:0], a[31:16], b[15:0], b[31:16]);
		hold_idle(2);
		check_eq(info, header_model(mode, r[1:0], a[15:0], a[31:16], b[15:0], b[31:16]),
			$sformatf("header info in mode %0d", mode));
		finish_sweep();
	endtask

	task automatic cheat_file(input int ncodes);
		logic [31:0] v;
		dl_word_t    w [CHEAT_WORDS];
		valid_seen = 0;
		dl.index   = 8'hFF;
		for (int k = 0; k < ncodes; k++) begin
			for (int i = 0; i < CHEAT_WORDS; i++) begin
				take_bits(lfsr_main, 16, v);
				w[i] = v[15:0];
			end
			// Flags, address, compare, replace with the low word of each first
			code_exp = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
			for (int i = 0; i < CHEAT_WORDS; i++) begin
				write_word(dl_addr_t'(16 * k + 2 * i), w[i]);
				take_bits(lfsr_main, 1, v);
				if (v[0])
					hold_idle(1);
			end
			hold_idle(1);
		end
		hold_idle(1);
		dl.download = 1'b0;
		hold_idle(2);
		check_eq(valid_seen, ncodes, "cheat_valid pulses");
	endtask

	task automatic backup_load;
		logic [31:0] a;
		logic [31:0] r;
		dl_word_t    d0;
		cart_info_t  want;
		take_bits(lfsr_main, 32, a);
		take_bits(lfsr_main, 2, r);
		// RAM size code 1 to 3 keeps the sector count small
		d0 = {a[15:8], 2'b00, (r[1:0] == 2'd0) ? 2'd1 : r[1:0], a[3:0]};
		want = header_model(3'd0, 2'd1, d0, a[31:16], 16'h0, 16'h0);
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_size     = 64'h10000;
		exp_rd       = 1'b1;
		exp_lba      = '0;
		load_cart(3'd0, 2'd1, d0, a[31:16], 16'h0, 16'h0);
		hold_idle(1);
		check_eq(bk_busy, 1'b0, "bk_busy at finish");
		hold_idle(1);
		check_eq(bk_busy, 1'b1, "backup load start");
		check_eq(info, want, "header info before restore");
		while (bk_busy)
			@(negedge clk_sys);
		check_eq(exp_lba, (want.ram_mask >> 9) + 1, "sectors read");
		check_eq(bk_loading, 1'b0, "bk_loading after restore");
		finish_sweep();

		// Restore on request once the sweep is over so bk_loading alone holds the core
		exp_rd       = 1'b1;
		exp_lba      = '0;
		cfg.load_req = 1'b1;
		hold_idle(1);
		cfg.load_req = 1'b0;
		check_eq(bk_loading, 1'b1, "restore on load_req");
		while (bk_busy)
			@(negedge clk_sys);
		check_eq(exp_lba, (want.ram_mask >> 9) + 1, "sectors read on load_req");
		check_eq(system_reset, 1'b0, "system_reset after restore");
	endtask

	task automatic backup_save;
		osd_open     = 1'b0;
		cfg.autosave = 1'b1;
		hold_idle(1);
		bsram_write = 1'b1;
		hold_idle(1);
		bsram_write = 1'b0;
		check_eq(bk_pending, 1'b1, "bk_pending after bsram_write");
		exp_rd  = 1'b0;
		exp_lba = '0;
		hold_idle(2);
		check_eq(bk_busy, 1'b0, "save with OSD closed");
		osd_open = 1'b1;
		hold_idle(1);
		check_eq(bk_busy, 1'b1, "autosave start");
		while (bk_busy)
			@(negedge clk_sys);
		check_eq(exp_lba, (info.ram_mask >> 9) + 1, "sectors written");
		check_eq(bk_pending, 1'b0, "bk_pending after save");
		osd_open = 1'b0;
	endtask

	// ====================
	// Monitors
	// ====================
	always @(negedge clk_sys) begin
		if (!RESET) begin
			check_eq(sd_rd && sd_wr, 1'b0, "sd_rd together with sd_wr");
			check_eq(cheat_valid && cheat_prev, 1'b0, "cheat_valid longer than a cycle");
			if (fill_wr) begin
				if (!fill_prev)
					check_eq($time, rise_time + 2 * CLK_PERIOD, "clear sweep start");
				check_eq(fill_addr, fill_cnt, "fill_addr");
				check_eq(system_reset, 1'b1, "system_reset during sweep");
				fill_cnt++;
			end else if (fill_prev) begin
				check_eq(fill_cnt, SWEEP_CYCLES, "clear sweep length");
				sweeps_done++;
				fill_cnt = 0;
			end
		end
		cheat_prev = cheat_valid;
		fill_prev  = fill_wr;
	end

	// SD side acknowledges each request after a random delay
	always begin : sd_responder
		logic [31:0] d;
		@(negedge clk_sys);
		if (!RESET && (sd_rd || sd_wr)) begin
			check_eq(sd_rd, exp_rd, "request direction");
			check_eq(sd_lba, exp_lba, "sector number");
			check_eq(bk_loading, exp_rd, "bk_loading during transfer");
			if (exp_rd)
				check_eq(system_reset, 1'b1, "system_reset during restore");
			exp_lba = exp_lba + 1;
			take_bits(lfsr_sd, 3, d);
			repeat (d) begin
				@(negedge clk_sys);
				check_eq(sd_rd || sd_wr, 1'b1, "request held until ack");
			end
			sd_ack = 1'b1;
			take_bits(lfsr_sd, 2, d);
			repeat (d + 1)
				@(negedge clk_sys);
			sd_ack = 1'b0;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout, the tests did not complete in time");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : main_seq
		logic [31:0] v;
		lfsr_main    = 32'h70d1d5a4;
		lfsr_sd      = 32'h70d1d5a4;
		errors       = 0;
		RESET        = 1'b1;
		dl           = '0;
		cfg          = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		sd_ack       = 1'b0;
		bsram_write  = 1'b0;
		osd_open     = 1'b0;
		exp_valid    = 1'b0;
		exp_first    = 1'b0;
		exp_rd       = 1'b0;
		exp_lba      = '0;
		rise_time    = 0;
		fill_cnt     = 0;
		fill_prev    = 1'b0;
		cheat_prev   = 1'b0;
		sweeps_done  = 0;
		loads_done   = 0;
		repeat (16) @(negedge clk_sys);
		RESET = 1'b0;

		for (int m = 0; m < 5; m++)
			header_case(header_mode_t'(m));
		for (int n = 0; n < 2; n++) begin
			take_bits(lfsr_main, 3, v);
			header_case(header_mode_t'(v % 5));
		end
		for (int n = 0; n < N_CHEATS; n++)
			cheat_file(2);
		backup_load();
		backup_save();
		hold_idle(4);

		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/load_pkg.sv
source/cart_pkg.sv
source/load_sequencer.sv
source/cart_header_detect.sv
source/cheat_code_loader.sv
source/backup_sync.sv
source/cart_loader_top.sv
verification/cart_loader_asserts.sv
verification/cart_loader_tb.sv
